// ==== hdl/addr_translate.sv ====
`timescale 1ns/100ps

module addr_translate (
    input  mmu_pkg::vaddr_t  vaddr,
    input  logic             store,
    input  mmu_pkg::asid_t   cur_asid,
    // TLB search results
    input  logic             found,
    input  mmu_pkg::pfn_t    pfn0,
    input  mmu_pkg::cattr_t  c0,       // For a later cache stage
    input  logic             d0,
    input  logic             v0,
    input  mmu_pkg::pfn_t    pfn1,
    input  mmu_pkg::cattr_t  c1,
    input  logic             d1,
    input  logic             v1,
    output mmu_pkg::vpn2_t   search_vpn2,
    output mmu_pkg::asid_t   search_asid,
    output mmu_pkg::paddr_t  paddr,
    output logic             refill,
    output logic             invalid,
    output logic             modified
);

    logic          unmapped;
    logic          odd_page;
    mmu_pkg::pfn_t page_pfn;
    logic          page_d;
    logic          page_v;

    // kseg0 and kseg1 bypass the TLB
    assign unmapped = (vaddr[31:30] == 2'b10);

    assign search_vpn2 = vaddr[31:13];
    assign search_asid = cur_asid;

    // Bit 12 selects the odd page of the pair
    assign odd_page = vaddr[12];
    assign page_pfn = odd_page ? pfn1 : pfn0;
    assign page_d   = odd_page ? d1 : d0;
    assign page_v   = odd_page ? v1 : v0;

    assign paddr = unmapped ? {3'b000, vaddr[28:0]} : {page_pfn, vaddr[11:0]};

    assign refill   = !unmapped && !found;
    assign invalid  = !unmapped && found && !page_v;
    assign modified = !unmapped && found && page_v && !page_d && store;  // Store to clean page

endmodule

// ==== hdl/cp0_tlb_regs.sv ====
`timescale 1ns/100ps

module cp0_tlb_regs #(
    parameter int tlb_num = 16
) (
    input  logic                       clk,
    input  logic                       reset,
    // Software access
    input  logic                       cp0_wen,
    input  mmu_pkg::cp0_addr_t         cp0_waddr,
    input  logic [31:0]                cp0_wdata,
    input  mmu_pkg::cp0_addr_t         cp0_raddr,
    output logic [31:0]                cp0_rdata,
    input  logic                       tlbwi,
    input  logic                       tlbp,
    input  logic                       tlbr,
    // Results from the TLB
    input  logic                       probe_found,
    input  logic [$clog2(tlb_num)-1:0] probe_index,
    input  mmu_pkg::vpn2_t             rd_vpn2,
    input  mmu_pkg::asid_t             rd_asid,
    input  logic                       rd_g,
    input  mmu_pkg::pfn_t              rd_pfn0,
    input  mmu_pkg::cattr_t            rd_c0,
    input  logic                       rd_d0,
    input  logic                       rd_v0,
    input  mmu_pkg::pfn_t              rd_pfn1,
    input  mmu_pkg::cattr_t            rd_c1,
    input  logic                       rd_d1,
    input  logic                       rd_v1,
    // Toward the TLB and translators
    output mmu_pkg::asid_t             cur_asid,
    output logic [$clog2(tlb_num)-1:0] tlb_index,
    output logic                       tlb_we,
    output logic                       probe_en,
    output mmu_pkg::vpn2_t             ent_vpn2,
    output mmu_pkg::asid_t             ent_asid,
    output logic                       ent_g0,
    output logic                       ent_g1,
    output mmu_pkg::pfn_t              ent_pfn0,
    output mmu_pkg::cattr_t            ent_c0,
    output logic                       ent_d0,
    output logic                       ent_v0,
    output mmu_pkg::pfn_t              ent_pfn1,
    output mmu_pkg::cattr_t            ent_c1,
    output logic                       ent_d1,
    output logic                       ent_v1
);

    localparam int          idx_w      = $clog2(tlb_num);
    localparam logic [31:0] index_mask = 32'h8000_0000 | ((32'd1 << idx_w) - 32'd1);
    localparam logic [31:0] hi_mask    = 32'hffff_e0ff;  // vpn2 and asid
    localparam logic [31:0] lo_mask    = 32'h03ff_ffff;  // pfn, c, d, v, g

    // Registers kept in their software layout, unused bits always zero
    logic [31:0] index_reg;
    logic [31:0] entry_hi;
    logic [31:0] entry_lo0;
    logic [31:0] entry_lo1;

    always_ff @(posedge clk) begin
        if (reset) begin
            index_reg <= '0;
            entry_hi  <= '0;
            entry_lo0 <= '0;
            entry_lo1 <= '0;
        end else if (cp0_wen) begin
            case (cp0_waddr)
                mmu_pkg::CP0_INDEX:    index_reg <= cp0_wdata & index_mask;
                mmu_pkg::CP0_ENTRYHI:  entry_hi  <= cp0_wdata & hi_mask;
                mmu_pkg::CP0_ENTRYLO0: entry_lo0 <= cp0_wdata & lo_mask;
                mmu_pkg::CP0_ENTRYLO1: entry_lo1 <= cp0_wdata & lo_mask;
                default: ;
            endcase
        end else if (tlbp) begin
            index_reg[31] <= !probe_found;
            if (probe_found)
                index_reg[idx_w-1:0] <= probe_index;  // Miss keeps the old index
        end else if (tlbr) begin
            entry_hi  <= {rd_vpn2, 5'b0, rd_asid};
            entry_lo0 <= {6'b0, rd_pfn0, rd_c0, rd_d0, rd_v0, rd_g};
            entry_lo1 <= {6'b0, rd_pfn1, rd_c1, rd_d1, rd_v1, rd_g};
        end
    end

    always_comb begin
        case (cp0_raddr)
            mmu_pkg::CP0_INDEX:    cp0_rdata = index_reg;
            mmu_pkg::CP0_ENTRYHI:  cp0_rdata = entry_hi;
            mmu_pkg::CP0_ENTRYLO0: cp0_rdata = entry_lo0;
            mmu_pkg::CP0_ENTRYLO1: cp0_rdata = entry_lo1;
            default:               cp0_rdata = '0;
        endcase
    end

    // Strobes pass straight on, TLB acts at the same edge
    assign tlb_we    = tlbwi;
    assign probe_en  = tlbp;
    assign tlb_index = index_reg[idx_w-1:0];

    assign ent_vpn2 = entry_hi[31:13];
    assign ent_asid = entry_hi[7:0];
    assign cur_asid = entry_hi[7:0];

    assign ent_pfn0 = entry_lo0[25:6];
    assign ent_c0   = entry_lo0[5:3];
    assign ent_d0   = entry_lo0[2];
    assign ent_v0   = entry_lo0[1];
    assign ent_g0   = entry_lo0[0];

    assign ent_pfn1 = entry_lo1[25:6];
    assign ent_c1   = entry_lo1[5:3];
    assign ent_d1   = entry_lo1[2];
    assign ent_v1   = entry_lo1[1];
    assign ent_g1   = entry_lo1[0];

endmodule

// ==== hdl/mmu_pkg.sv ====
package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;     // Page pair, vaddr 31..13
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [4:0]  cp0_addr_t;

    // CP0 register numbers
    localparam cp0_addr_t CP0_INDEX    = 5'd0;
    localparam cp0_addr_t CP0_ENTRYLO0 = 5'd2;
    localparam cp0_addr_t CP0_ENTRYLO1 = 5'd3;
    localparam cp0_addr_t CP0_ENTRYHI  = 5'd10;

endpackage

// ==== hdl/mmu_top.sv ====
`timescale 1ns/100ps

module mmu_top #(
    parameter int tlb_num = 16
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               cp0_wen,
    input  mmu_pkg::cp0_addr_t cp0_waddr,
    input  logic [31:0]        cp0_wdata,
    input  mmu_pkg::cp0_addr_t cp0_raddr,
    output logic [31:0]        cp0_rdata,
    input  logic               tlbwi,
    input  logic               tlbp,
    input  logic               tlbr,
    // Fetch side
    input  mmu_pkg::vaddr_t    inst_vaddr,
    output mmu_pkg::paddr_t    inst_paddr,
    output logic               inst_refill,
    output logic               inst_invalid,
    // Data side
    input  mmu_pkg::vaddr_t    data_vaddr,
    input  logic               data_store,
    output mmu_pkg::paddr_t    data_paddr,
    output logic               data_refill,
    output logic               data_invalid,
    output logic               data_modified
);

    localparam int idx_w = $clog2(tlb_num);

    mmu_pkg::asid_t   cur_asid;
    logic [idx_w-1:0] tlb_index;
    logic             tlb_we;
    logic             probe_en;
    logic             probe_found;
    logic [idx_w-1:0] probe_index;

    // Entry written by tlbwi
    mmu_pkg::vpn2_t   ent_vpn2;
    mmu_pkg::asid_t   ent_asid;
    logic             ent_g0;
    logic             ent_g1;
    mmu_pkg::pfn_t    ent_pfn0;
    mmu_pkg::cattr_t  ent_c0;
    logic             ent_d0;
    logic             ent_v0;
    mmu_pkg::pfn_t    ent_pfn1;
    mmu_pkg::cattr_t  ent_c1;
    logic             ent_d1;
    logic             ent_v1;

    // Entry read back by tlbr
    mmu_pkg::vpn2_t   rd_vpn2;
    mmu_pkg::asid_t   rd_asid;
    logic             rd_g;
    mmu_pkg::pfn_t    rd_pfn0;
    mmu_pkg::cattr_t  rd_c0;
    logic             rd_d0;
    logic             rd_v0;
    mmu_pkg::pfn_t    rd_pfn1;
    mmu_pkg::cattr_t  rd_c1;
    logic             rd_d1;
    logic             rd_v1;

    mmu_pkg::vpn2_t   inst_vpn2;
    mmu_pkg::asid_t   inst_asid;
    logic             inst_found;
    mmu_pkg::pfn_t    inst_pfn0;
    logic             inst_d0;
    logic             inst_v0;
    mmu_pkg::pfn_t    inst_pfn1;
    logic             inst_d1;
    logic             inst_v1;

    mmu_pkg::vpn2_t   data_vpn2;
    mmu_pkg::asid_t   data_asid;
    logic             data_found;
    mmu_pkg::pfn_t    data_pfn0;
    logic             data_d0;
    logic             data_v0;
    mmu_pkg::pfn_t    data_pfn1;
    logic             data_d1;
    logic             data_v1;

    cp0_tlb_regs #(
        .tlb_num (tlb_num)
    ) i_cp0_tlb_regs (
        .clk         (clk),
        .reset       (reset),
        .cp0_wen     (cp0_wen),
        .cp0_waddr   (cp0_waddr),
        .cp0_wdata   (cp0_wdata),
        .cp0_raddr   (cp0_raddr),
        .cp0_rdata   (cp0_rdata),
        .tlbwi       (tlbwi),
        .tlbp        (tlbp),
        .tlbr        (tlbr),
        .probe_found (probe_found),
        .probe_index (probe_index),
        .rd_vpn2     (rd_vpn2),
        .rd_asid     (rd_asid),
        .rd_g        (rd_g),
        .rd_pfn0     (rd_pfn0),
        .rd_c0       (rd_c0),
        .rd_d0       (rd_d0),
        .rd_v0       (rd_v0),
        .rd_pfn1     (rd_pfn1),
        .rd_c1       (rd_c1),
        .rd_d1       (rd_d1),
        .rd_v1       (rd_v1),
        .cur_asid    (cur_asid),
        .tlb_index   (tlb_index),
        .tlb_we      (tlb_we),
        .probe_en    (probe_en),
        .ent_vpn2    (ent_vpn2),
        .ent_asid    (ent_asid),
        .ent_g0      (ent_g0),
        .ent_g1      (ent_g1),
        .ent_pfn0    (ent_pfn0),
        .ent_c0      (ent_c0),
        .ent_d0      (ent_d0),
        .ent_v0      (ent_v0),
        .ent_pfn1    (ent_pfn1),
        .ent_c1      (ent_c1),
        .ent_d1      (ent_d1),
        .ent_v1      (ent_v1)
    );

    tlb #(
        .tlb_num (tlb_num)
    ) i_tlb (
        .clk         (clk),
        .reset       (reset),
        .tlb_we      (tlb_we),
        .tlb_index   (tlb_index),
        .probe_en    (probe_en),
        .ent_vpn2    (ent_vpn2),
        .ent_asid    (ent_asid),
        .ent_g0      (ent_g0),
        .ent_g1      (ent_g1),
        .ent_pfn0    (ent_pfn0),
        .ent_c0      (ent_c0),
        .ent_d0      (ent_d0),
        .ent_v0      (ent_v0),
        .ent_pfn1    (ent_pfn1),
        .ent_c1      (ent_c1),
        .ent_d1      (ent_d1),
        .ent_v1      (ent_v1),
        .inst_vpn2   (inst_vpn2),
        .inst_asid   (inst_asid),
        .inst_found  (inst_found),
        .inst_pfn0   (inst_pfn0),
        .inst_c0     (),
        .inst_d0     (inst_d0),
        .inst_v0     (inst_v0),
        .inst_pfn1   (inst_pfn1),
        .inst_c1     (),
        .inst_d1     (inst_d1),
        .inst_v1     (inst_v1),
        .data_vpn2   (data_vpn2),
        .data_asid   (data_asid),
        .data_found  (data_found),
        .data_pfn0   (data_pfn0),
        .data_c0     (),
        .data_d0     (data_d0),
        .data_v0     (data_v0),
        .data_pfn1   (data_pfn1),
        .data_c1     (),
        .data_d1     (data_d1),
        .data_v1     (data_v1),
        .probe_found (probe_found),
        .probe_index (probe_index),
        .rd_vpn2     (rd_vpn2),
        .rd_asid     (rd_asid),
        .rd_g        (rd_g),
        .rd_pfn0     (rd_pfn0),
        .rd_c0       (rd_c0),
        .rd_d0       (rd_d0),
        .rd_v0       (rd_v0),
        .rd_pfn1     (rd_pfn1),
        .rd_c1       (rd_c1),
        .rd_d1       (rd_d1),
        .rd_v1       (rd_v1)
    );

    // Fetch never stores
    addr_translate i_inst_xlate (
        .vaddr       (inst_vaddr),
        .store       (1'b0),
        .cur_asid    (cur_asid),
        .found       (inst_found),
        .pfn0        (inst_pfn0),
        .c0          (),
        .d0          (inst_d0),
        .v0          (inst_v0),
        .pfn1        (inst_pfn1),
        .c1          (),
        .d1          (inst_d1),
        .v1          (inst_v1),
        .search_vpn2 (inst_vpn2),
        .search_asid (inst_asid),
        .paddr       (inst_paddr),
        .refill      (inst_refill),
        .invalid     (inst_invalid),
        .modified    ()
    );

    addr_translate i_data_xlate (
        .vaddr       (data_vaddr),
        .store       (data_store),
        .cur_asid    (cur_asid),
        .found       (data_found),
        .pfn0        (data_pfn0),
        .c0          (),
        .d0          (data_d0),
        .v0          (data_v0),
        .pfn1        (data_pfn1),
        .c1          (),
        .d1          (data_d1),
        .v1          (data_v1),
        .search_vpn2 (data_vpn2),
        .search_asid (data_asid),
        .paddr       (data_paddr),
        .refill      (data_refill),
        .invalid     (data_invalid),
        .modified    (data_modified)
    );

endmodule

// ==== hdl/tlb.sv ====
`timescale 1ns/100ps

module tlb #(
    parameter int tlb_num = 16
) (
    input  logic                       clk,
    input  logic                       reset,
    // Write and probe control from CP0
    input  logic                       tlb_we,
    input  logic [$clog2(tlb_num)-1:0] tlb_index,
    input  logic                       probe_en,
    input  mmu_pkg::vpn2_t             ent_vpn2,
    input  mmu_pkg::asid_t             ent_asid,
    input  logic                       ent_g0,
    input  logic                       ent_g1,
    input  mmu_pkg::pfn_t              ent_pfn0,
    input  mmu_pkg::cattr_t            ent_c0,
    input  logic                       ent_d0,
    input  logic                       ent_v0,
    input  mmu_pkg::pfn_t              ent_pfn1,
    input  mmu_pkg::cattr_t            ent_c1,
    input  logic                       ent_d1,
    input  logic                       ent_v1,
    // Fetch search port
    input  mmu_pkg::vpn2_t             inst_vpn2,
    input  mmu_pkg::asid_t             inst_asid,
    output logic                       inst_found,
    output mmu_pkg::pfn_t              inst_pfn0,
    output mmu_pkg::cattr_t            inst_c0,
    output logic                       inst_d0,
    output logic                       inst_v0,
    output mmu_pkg::pfn_t              inst_pfn1,
    output mmu_pkg::cattr_t            inst_c1,
    output logic                       inst_d1,
    output logic                       inst_v1,
    // Data search port, shared with tlbp
    input  mmu_pkg::vpn2_t             data_vpn2,
    input  mmu_pkg::asid_t             data_asid,
    output logic                       data_found,
    output mmu_pkg::pfn_t              data_pfn0,
    output mmu_pkg::cattr_t            data_c0,
    output logic                       data_d0,
    output logic                       data_v0,
    output mmu_pkg::pfn_t              data_pfn1,
    output mmu_pkg::cattr_t            data_c1,
    output logic                       data_d1,
    output logic                       data_v1,
    output logic                       probe_found,
    output logic [$clog2(tlb_num)-1:0] probe_index,
    // Entry at tlb_index for tlbr
    output mmu_pkg::vpn2_t             rd_vpn2,
    output mmu_pkg::asid_t             rd_asid,
    output logic                       rd_g,
    output mmu_pkg::pfn_t              rd_pfn0,
    output mmu_pkg::cattr_t            rd_c0,
    output logic                       rd_d0,
    output logic                       rd_v0,
    output mmu_pkg::pfn_t              rd_pfn1,
    output mmu_pkg::cattr_t            rd_c1,
    output logic                       rd_d1,
    output logic                       rd_v1
);

    localparam int idx_w = $clog2(tlb_num);

    mmu_pkg::vpn2_t     tlb_vpn2 [tlb_num];
    mmu_pkg::asid_t     tlb_asid [tlb_num];
    logic               tlb_g    [tlb_num];
    mmu_pkg::pfn_t      tlb_pfn0 [tlb_num];
    mmu_pkg::cattr_t    tlb_c0   [tlb_num];
    logic               tlb_d0   [tlb_num];
    logic               tlb_v0   [tlb_num];
    mmu_pkg::pfn_t      tlb_pfn1 [tlb_num];
    mmu_pkg::cattr_t    tlb_c1   [tlb_num];
    logic               tlb_d1   [tlb_num];
    logic               tlb_v1   [tlb_num];

    logic [tlb_num-1:0] inst_match;
    logic [tlb_num-1:0] data_match;
    logic [idx_w-1:0]   inst_sel;
    logic [idx_w-1:0]   data_sel;
    mmu_pkg::vpn2_t     data_key_vpn2;
    mmu_pkg::asid_t     data_key_asid;

    // One-hot match vector to entry number
    function automatic logic [idx_w-1:0] onehot_index(input logic [tlb_num-1:0] match);
        logic [idx_w-1:0] idx;
        idx = '0;
        for (int k = 0; k < tlb_num; k++) begin
            if (match[k])
                idx = idx | idx_w'(k);
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_num; i++) begin
                tlb_vpn2[i] <= '0;
                tlb_asid[i] <= '0;
                tlb_g[i]    <= 1'b0;
                tlb_pfn0[i] <= '0;
                tlb_c0[i]   <= '0;
                tlb_d0[i]   <= 1'b0;
                tlb_v0[i]   <= 1'b0;
                tlb_pfn1[i] <= '0;
                tlb_c1[i]   <= '0;
                tlb_d1[i]   <= 1'b0;
                tlb_v1[i]   <= 1'b0;
            end
        end else if (tlb_we) begin
            tlb_vpn2[tlb_index] <= ent_vpn2;
            tlb_asid[tlb_index] <= ent_asid;
            tlb_g[tlb_index]    <= ent_g0 & ent_g1;  // Global only if both halves say so
            tlb_pfn0[tlb_index] <= ent_pfn0;
            tlb_c0[tlb_index]   <= ent_c0;
            tlb_d0[tlb_index]   <= ent_d0;
            tlb_v0[tlb_index]   <= ent_v0;
            tlb_pfn1[tlb_index] <= ent_pfn1;
            tlb_c1[tlb_index]   <= ent_c1;
            tlb_d1[tlb_index]   <= ent_d1;
            tlb_v1[tlb_index]   <= ent_v1;
        end
    end

    // tlbp borrows the data port
    assign data_key_vpn2 = probe_en ? ent_vpn2 : data_vpn2;
    assign data_key_asid = probe_en ? ent_asid : data_asid;

    for (genvar n = 0; n < tlb_num; n++) begin : g_match
        assign inst_match[n] = (inst_vpn2 == tlb_vpn2[n])
                            && ((inst_asid == tlb_asid[n]) || tlb_g[n]);
        assign data_match[n] = (data_key_vpn2 == tlb_vpn2[n])
                            && ((data_key_asid == tlb_asid[n]) || tlb_g[n]);
    end

    assign inst_sel = onehot_index(inst_match);
    assign data_sel = onehot_index(data_match);

    assign inst_found = |inst_match;
    assign inst_pfn0  = tlb_pfn0[inst_sel];
    assign inst_c0    = tlb_c0[inst_sel];
    assign inst_d0    = tlb_d0[inst_sel];
    assign inst_v0    = tlb_v0[inst_sel];
    assign inst_pfn1  = tlb_pfn1[inst_sel];
    assign inst_c1    = tlb_c1[inst_sel];
    assign inst_d1    = tlb_d1[inst_sel];
    assign inst_v1    = tlb_v1[inst_sel];

    assign data_found = |data_match;
    assign data_pfn0  = tlb_pfn0[data_sel];
    assign data_c0    = tlb_c0[data_sel];
    assign data_d0    = tlb_d0[data_sel];
    assign data_v0    = tlb_v0[data_sel];
    assign data_pfn1  = tlb_pfn1[data_sel];
    assign data_c1    = tlb_c1[data_sel];
    assign data_d1    = tlb_d1[data_sel];
    assign data_v1    = tlb_v1[data_sel];

    assign probe_found = |data_match;
    assign probe_index = data_sel;

    assign rd_vpn2 = tlb_vpn2[tlb_index];
    assign rd_asid = tlb_asid[tlb_index];
    assign rd_g    = tlb_g[tlb_index];
    assign rd_pfn0 = tlb_pfn0[tlb_index];
    assign rd_c0   = tlb_c0[tlb_index];
    assign rd_d0   = tlb_d0[tlb_index];
    assign rd_v0   = tlb_v0[tlb_index];
    assign rd_pfn1 = tlb_pfn1[tlb_index];
    assign rd_c1   = tlb_c1[tlb_index];
    assign rd_d1   = tlb_d1[tlb_index];
    assign rd_v1   = tlb_v1[tlb_index];

endmodule

// ==== mmu_sub.f ====
hdl/mmu_pkg.sv
hdl/addr_translate.sv
hdl/tlb.sv
hdl/cp0_tlb_regs.sv
hdl/mmu_top.sv
test/mmu_props.sv
test/tb_mmu.sv

// ==== test/mmu_props.sv ====
`timescale 1ns/100ps

module mmu_props (
    input logic                  clk,
    input logic                  reset,
    input mmu_pkg::vaddr_t       inst_vaddr,
    input mmu_pkg::paddr_t       inst_paddr,
    input logic                  inst_refill,
    input logic                  inst_invalid,
    input mmu_pkg::vaddr_t       data_vaddr,
    input mmu_pkg::paddr_t       data_paddr,
    input logic                  data_refill,
    input logic                  data_invalid,
    input logic                  data_modified,
    input logic                  tlb_we,
    input logic                  probe_en,
    input logic [31:0]           cp0_rdata
);

    int   fail_count = 0;
    logic reset_q = 1'b0;  // High from the second reset cycle on

    always @(posedge clk)
        reset_q <= reset;

    inst_unmapped: assert property (@(posedge clk) disable iff (reset)
        inst_vaddr[31:30] == 2'b10 |->
            inst_paddr == {3'b000, inst_vaddr[28:0]} && !inst_refill && !inst_invalid)
    else begin
        $error("fetch unmapped address translated wrongly or flagged");
        fail_count = fail_count + 1;
    end

    data_unmapped: assert property (@(posedge clk) disable iff (reset)
        data_vaddr[31:30] == 2'b10 |->
            data_paddr == {3'b000, data_vaddr[28:0]}
            && !data_refill && !data_invalid && !data_modified)
    else begin
        $error("data unmapped address translated wrongly or flagged");
        fail_count = fail_count + 1;
    end

    inst_one_flag: assert property (@(posedge clk) disable iff (reset)
        $onehot0({inst_refill, inst_invalid}))
    else begin
        $error("more than one fetch exception flag");
        fail_count = fail_count + 1;
    end

    data_one_flag: assert property (@(posedge clk) disable iff (reset)
        $onehot0({data_refill, data_invalid, data_modified}))
    else begin
        $error("more than one data exception flag");
        fail_count = fail_count + 1;
    end

    reset_quiet: assert property (@(posedge clk)
        reset |-> !tlb_we && !probe_en && (!reset_q || cp0_rdata == '0))
    else begin
        $error("strobe or nonzero CP0 read during reset");
        fail_count = fail_count + 1;
    end

endmodule

bind mmu_top mmu_props i_mmu_props (
    .clk           (clk),
    .reset         (reset),
    .inst_vaddr    (inst_vaddr),
    .inst_paddr    (inst_paddr),
    .inst_refill   (inst_refill),
    .inst_invalid  (inst_invalid),
    .data_vaddr    (data_vaddr),
    .data_paddr    (data_paddr),
    .data_refill   (data_refill),
    .data_invalid  (data_invalid),
    .data_modified (data_modified),
    .tlb_we        (tlb_we),
    .probe_en      (probe_en),
    .cp0_rdata     (cp0_rdata)
);

// ==== test/tb_mmu.sv ====
`timescale 1ns/100ps

module tb_mmu;

    localparam int cycle_limit = 3000;  // Tests take about 400 cycles

    logic               clk = 1'b0;
    logic               reset;
    logic               cp0_wen;
    mmu_pkg::cp0_addr_t cp0_waddr;
    logic [31:0]        cp0_wdata;
    mmu_pkg::cp0_addr_t cp0_raddr;
    logic [31:0]        cp0_rdata;
    logic               tlbwi;
    logic               tlbp;
    logic               tlbr;
    mmu_pkg::vaddr_t    inst_vaddr;
    mmu_pkg::paddr_t    inst_paddr;
    logic               inst_refill;
    logic               inst_invalid;
    mmu_pkg::vaddr_t    data_vaddr;
    logic               data_store;
    mmu_pkg::paddr_t    data_paddr;
    logic               data_refill;
    logic               data_invalid;
    logic               data_modified;

    // Shadow TLB in CP0 register layout
    logic [31:0] sh_hi  [16];
    logic [31:0] sh_lo0 [16];
    logic [31:0] sh_lo1 [16];
    logic [7:0]  asid_now;
    int          cycles = 0;

    mmu_top #(
        .tlb_num (16)
    ) i_mmu_top (
        .clk (clk), .reset (reset),
        .cp0_wen (cp0_wen), .cp0_waddr (cp0_waddr), .cp0_wdata (cp0_wdata),
        .cp0_raddr (cp0_raddr), .cp0_rdata (cp0_rdata),
        .tlbwi (tlbwi), .tlbp (tlbp), .tlbr (tlbr),
        .inst_vaddr (inst_vaddr), .inst_paddr (inst_paddr),
        .inst_refill (inst_refill), .inst_invalid (inst_invalid),
        .data_vaddr (data_vaddr), .data_store (data_store), .data_paddr (data_paddr),
        .data_refill (data_refill), .data_invalid (data_invalid),
        .data_modified (data_modified)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, tests did not finish", cycles);
            $display("Test failed");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        if (i_mmu_top.i_mmu_props.fail_count != 0) begin
            $display("Bound assertion failed in cycle %0d", cycles);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic cp0_write(input mmu_pkg::cp0_addr_t addr, input logic [31:0] data);
        cp0_wen   <= 1'b1;
        cp0_waddr <= addr;
        cp0_wdata <= data;
        @(posedge clk);
        cp0_wen   <= 1'b0;
    endtask

    task automatic check_reg(input string name, input mmu_pkg::cp0_addr_t addr,
                             input logic [31:0] exp);
        cp0_raddr <= addr;
        @(negedge clk);
        expect_eq(name, exp, cp0_rdata);
        @(posedge clk);
    endtask

    task automatic strobe(input logic wi, input logic p, input logic r);
        tlbwi <= wi;
        tlbp  <= p;
        tlbr  <= r;
        @(posedge clk);
        tlbwi <= 1'b0;
        tlbp  <= 1'b0;
        tlbr  <= 1'b0;
    endtask

    task automatic set_asid(input logic [7:0] asid);
        cp0_write(mmu_pkg::CP0_ENTRYHI, {24'h0, asid});
        asid_now = asid;
    endtask

    // Expected paddr and {refill, invalid, modified} from the shadow entries
    function automatic void predict(input logic [31:0] va, input logic [7:0] asid,
                                    input logic st, output logic [31:0] pa,
                                    output logic [2:0] flags);
        logic        hit;
        logic [31:0] lo;
        hit = 1'b0;
        lo  = '0;
        for (int k = 0; k < 16; k++) begin
            if (sh_hi[k][31:13] == va[31:13]
                && (sh_hi[k][7:0] == asid || (sh_lo0[k][0] && sh_lo1[k][0]))) begin
                hit = 1'b1;
                lo  = va[12] ? sh_lo1[k] : sh_lo0[k];
            end
        end
        if (va[31:30] == 2'b10) begin
            pa    = {3'b000, va[28:0]};
            flags = 3'b000;
        end else begin
            pa    = {lo[25:6], va[11:0]};
            flags = {!hit, hit && !lo[1], hit && lo[1] && !lo[2] && st};
        end
    endfunction

    task automatic check_xlate(input string name, input logic [31:0] va, input logic st);
        logic [31:0] exp_pa;
        logic [2:0]  exp_fl;
        inst_vaddr <= va;
        data_vaddr <= va;
        data_store <= st;
        @(negedge clk);
        predict(va, asid_now, 1'b0, exp_pa, exp_fl);
        expect_eq({name, " inst flags"}, exp_fl, {inst_refill, inst_invalid, 1'b0});
        if (!exp_fl[2])
            expect_eq({name, " inst paddr"}, exp_pa, inst_paddr);  // Undefined on refill
        predict(va, asid_now, st, exp_pa, exp_fl);
        expect_eq({name, " data flags"}, exp_fl, {data_refill, data_invalid, data_modified});
        if (!exp_fl[2])
            expect_eq({name, " data paddr"}, exp_pa, data_paddr);
        @(posedge clk);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [18:0] vpn2;
        logic        g;
        reset      = 1'b1;
        cp0_wen    = 1'b0;
        cp0_waddr  = '0;
        cp0_wdata  = '0;
        cp0_raddr  = '0;
        tlbwi      = 1'b0;
        tlbp       = 1'b0;
        tlbr       = 1'b0;
        inst_vaddr = 32'h8000_0000;
        data_vaddr = 32'ha000_0000;
        data_store = 1'b0;
        asid_now   = '0;
        void'($urandom(32'h3073eac6));
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (int n = 0; n < 16; n++) begin
            r = $urandom;
            check_xlate("unmapped", {2'b10, r[29:0]}, r[30]);
        end

        for (int i = 0; i < 16; i++) begin
            r  = $urandom;
            r2 = $urandom;
            vpn2    = {r[14:0], 4'(i)};  // Low bits keep every vpn2 unique
            vpn2[4] = 1'b1;
            if (vpn2[18:17] == 2'b10)
                vpn2[17] = 1'b1;
            sh_hi[i]  = {vpn2, 5'b0, r2[31:24]};
            r  = $urandom;
            r2 = $urandom;
            sh_lo0[i] = {6'b0, r[25:0]};
            sh_lo1[i] = {6'b0, r2[25:0]};
            sh_lo0[i][0] = sh_lo0[i][0] | (i % 4 == 0);
            sh_lo1[i][0] = (i % 4 == 0);
            if (i == 1)
                sh_lo0[i][1] = 1'b0;
            if (i == 2)
                sh_lo1[i][2:1] = 2'b01;  // Valid but clean
            cp0_write(mmu_pkg::CP0_INDEX, 32'(i));
            cp0_write(mmu_pkg::CP0_ENTRYHI, sh_hi[i]);
            cp0_write(mmu_pkg::CP0_ENTRYLO0, sh_lo0[i]);
            cp0_write(mmu_pkg::CP0_ENTRYLO1, sh_lo1[i]);
            strobe(1'b1, 1'b0, 1'b0);
        end

        for (int i = 0; i < 16; i++) begin
            g = sh_lo0[i][0] & sh_lo1[i][0];
            cp0_write(mmu_pkg::CP0_INDEX, 32'(i));
            strobe(1'b0, 1'b0, 1'b1);
            check_reg("read entryhi", mmu_pkg::CP0_ENTRYHI, sh_hi[i]);
            check_reg("read entrylo0", mmu_pkg::CP0_ENTRYLO0, {sh_lo0[i][31:1], g});
            check_reg("read entrylo1", mmu_pkg::CP0_ENTRYLO1, {sh_lo1[i][31:1], g});
        end

        // Own asid, then a foreign one where only global entries hit
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 16; i++) begin
                set_asid(pass == 0 ? sh_hi[i][7:0] : ~sh_hi[i][7:0]);
                for (int page = 0; page < 2; page++) begin
                    r = $urandom;
                    check_xlate("mapped load", {sh_hi[i][31:13], page[0], r[11:0]}, 1'b0);
                    check_xlate("mapped store", {sh_hi[i][31:13], page[0], r[11:0]}, 1'b1);
                end
            end
        end
        check_xlate("unwritten vpn2", {19'h00021, 13'h0abc}, 1'b0);

        for (int i = 0; i < 16; i++) begin
            cp0_write(mmu_pkg::CP0_ENTRYHI, sh_hi[i]);
            strobe(1'b0, 1'b1, 1'b0);
            check_reg("probe hit", mmu_pkg::CP0_INDEX, 32'(i));
        end
        cp0_write(mmu_pkg::CP0_ENTRYHI, {19'h00021, 13'h0});
        strobe(1'b0, 1'b1, 1'b0);
        check_reg("probe miss", mmu_pkg::CP0_INDEX, 32'h8000_000f);

        @(negedge clk);
        if (i_mmu_top.i_mmu_props.fail_count != 0) begin
            $display("%0d bound assertion failures", i_mmu_top.i_mmu_props.fail_count);
            $display("Test failed");
            $fatal(1);
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
